// File: hw/fabric_pkg.sv
package fabric_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bus geometry
	////////////////////////////////////////////////////////////////////////////

	// request address width
	localparam int ADDR_W = 16;
	// data word width
	localparam int DATA_W = 32;
	// one strobe bit per data byte
	localparam int STRB_W = DATA_W / 8;
	// tag width, echoed back in every response
	localparam int TAG_W = 4;

	// slaves in the bank
	localparam int NUM_SLAVES = 4;
	// word index inside a slave comes from address bits 5..2
	localparam int WORD_IDX_W = 4;
	localparam int IDX_LSB = 2;
	localparam int RAM_WORDS = 1 << WORD_IDX_W;

	////////////////////////////////////////////////////////////////////////////
	// address map
	////////////////////////////////////////////////////////////////////////////

	// slave 0 sits in the lowest ADDR_W bits of each table
	localparam logic [NUM_SLAVES*ADDR_W-1:0] SLAVE_ADDR = {
		16'h8000, 16'h2000, 16'h1000, 16'h0000 };
	localparam logic [NUM_SLAVES*ADDR_W-1:0] SLAVE_MASK = {
		16'h8000, 16'hF000, 16'hF000, 16'hF000 };
	// 0x3000..0x7fff belong to nobody

	// slave 2 is the id rom
	localparam int ROM_SLAVE = 2;
	// write channel may not reach the rom
	localparam logic [NUM_SLAVES-1:0] WR_ALLOWED = 4'b1011;
	// read channel may reach everything
	localparam logic [NUM_SLAVES-1:0] RD_ALLOWED = 4'b1111;

	// rom word n reads as this with the low nibble replaced by n
	localparam logic [DATA_W-1:0] ROM_ID = 32'hFAB1_C0D0;

	////////////////////////////////////////////////////////////////////////////
	// channel types
	////////////////////////////////////////////////////////////////////////////

	// one-hot slave select, top bit flags "no slave"
	typedef logic [NUM_SLAVES:0] decode_t;

	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} wr_req_t;

	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [ADDR_W-1:0] addr;
	} rd_req_t;

	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic              is_write;
		logic              err;
		logic [DATA_W-1:0] rdata;
	} rsp_t;

endpackage

// File: hw/addr_decode.sv
`timescale 1ns/1ps

module addr_decode #(
	parameter type PAYLOAD_T = logic,
	parameter logic [fabric_pkg::NUM_SLAVES-1:0] ACCESS_ALLOWED = '1
) (
	input  logic                          i_clk,
	input  logic                          i_reset,
	// incoming request
	input  logic                          i_valid,
	output logic                          o_stall,
	input  logic [fabric_pkg::ADDR_W-1:0] i_addr,
	input  PAYLOAD_T                      i_payload,
	// registered decoded request
	output logic                          o_valid,
	input  logic                          i_stall,
	output fabric_pkg::decode_t           o_decode,
	output PAYLOAD_T                      o_payload
);
	import fabric_pkg::*;

	// per-slave address match, already filtered by access rights
	logic [NUM_SLAVES-1:0] hit;
	// full decode including the no-slave bit
	decode_t               request;

	////////////////////////////////////////////////////////////////////////////
	// address compare
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int s = 0; s < NUM_SLAVES; s++)
		begin
			// only the masked address bits must equal the base
			hit[s] = (((i_addr ^ SLAVE_ADDR[s*ADDR_W +: ADDR_W])
				& SLAVE_MASK[s*ADDR_W +: ADDR_W]) == '0)
				&& ACCESS_ALLOWED[s];
		end
		// map has no overlaps so at most one hit bit is set
		// nothing matched or slave refused gives the error bit
		request = {~|hit, hit};
	end

	////////////////////////////////////////////////////////////////////////////
	// one-deep pipeline stage
	////////////////////////////////////////////////////////////////////////////

	// stall upstream only while holding a word the arbiter did not take
	assign o_stall = o_valid && i_stall;

	// control half of the stage
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_valid  <= 1'b0;
			o_decode <= '0;
		end
		else if (!o_stall)
		begin
			o_valid <= i_valid;
			// keep decode clear while the stage is empty
			if (i_valid)
				o_decode <= request;
			else
				o_decode <= '0;
		end
	end

	// payload half, follows the same load condition
	always_ff @(posedge i_clk)
	begin
		if (!o_stall)
			o_payload <= i_payload;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// a valid word selects exactly one target and an empty stage selects none
	a_decode_onehot : assert property (
		@(posedge i_clk) disable iff (i_reset)
		o_valid ? $onehot(o_decode) : (o_decode == '0)
	) else $error("decode not one-hot while valid or nonzero while idle");

	// held word must not move while the arbiter pushes back
	a_hold_on_stall : assert property (
		@(posedge i_clk) disable iff (i_reset)
		(o_valid && i_stall) |=>
			(o_valid && $stable(o_decode) && $stable(o_payload))
	) else $error("decoder output changed under stall");

endmodule

// File: hw/access_arbiter.sv
`timescale 1ns/1ps

module access_arbiter (
	input  logic                              i_clk,
	input  logic                              i_reset,
	// decoded write channel
	input  logic                              i_wr_valid,
	output logic                              o_wr_stall,
	input  fabric_pkg::decode_t               i_wr_decode,
	input  fabric_pkg::wr_req_t               i_wr_req,
	// decoded read channel
	input  logic                              i_rd_valid,
	output logic                              o_rd_stall,
	input  fabric_pkg::decode_t               i_rd_decode,
	input  fabric_pkg::rd_req_t               i_rd_req,
	// slave bank port
	output logic [fabric_pkg::NUM_SLAVES-1:0] o_bank_sel,
	output logic                              o_bank_we,
	output logic [fabric_pkg::WORD_IDX_W-1:0] o_bank_idx,
	output logic [fabric_pkg::DATA_W-1:0]     o_bank_wdata,
	output logic [fabric_pkg::STRB_W-1:0]     o_bank_strb,
	input  logic [fabric_pkg::DATA_W-1:0]     i_bank_rdata,
	// response port
	output logic                              o_rsp_valid,
	input  logic                              i_rsp_stall,
	output fabric_pkg::rsp_t                  o_rsp
);
	import fabric_pkg::*;

	// set when the write channel won the last grant
	logic last_wr;
	// response slot is empty or drains this edge
	logic rsp_free;
	// channel choice, before looking at the response slot
	logic wr_pick;
	logic rd_pick;
	// actual grants
	logic wr_grant;
	logic rd_grant;
	// chosen request went to the no-slave bit
	logic err;
	rsp_t rsp_next;

	////////////////////////////////////////////////////////////////////////////
	// channel choice
	////////////////////////////////////////////////////////////////////////////

	assign rsp_free = !o_rsp_valid || !i_rsp_stall;

	// on contention the channel not served last time goes first
	assign wr_pick = i_wr_valid && (!i_rd_valid || !last_wr);
	assign rd_pick = i_rd_valid && !wr_pick;

	assign wr_grant = rsp_free && wr_pick;
	assign rd_grant = rsp_free && rd_pick;

	// loser keeps its word until granted
	assign o_wr_stall = i_wr_valid && !wr_grant;
	assign o_rd_stall = i_rd_valid && !rd_grant;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			last_wr <= 1'b0;
		else if (wr_grant)
			last_wr <= 1'b1;
		else if (rd_grant)
			last_wr <= 1'b0;
	end

	////////////////////////////////////////////////////////////////////////////
	// slave access
	////////////////////////////////////////////////////////////////////////////

	// select bits stay low for a no-slave decode so the bank is untouched
	always_comb
	begin
		if (wr_grant)
			o_bank_sel = i_wr_decode[NUM_SLAVES-1:0];
		else if (rd_grant)
			o_bank_sel = i_rd_decode[NUM_SLAVES-1:0];
		else
			o_bank_sel = '0;
	end

	assign o_bank_we = wr_grant && (|i_wr_decode[NUM_SLAVES-1:0]);

	// word index from whichever request is in front
	assign o_bank_idx = wr_pick ? i_wr_req.addr[IDX_LSB +: WORD_IDX_W]
		: i_rd_req.addr[IDX_LSB +: WORD_IDX_W];
	assign o_bank_wdata = i_wr_req.data;
	assign o_bank_strb  = i_wr_req.strb;

	////////////////////////////////////////////////////////////////////////////
	// response register
	////////////////////////////////////////////////////////////////////////////

	assign err = wr_pick ? i_wr_decode[NUM_SLAVES] : i_rd_decode[NUM_SLAVES];

	always_comb
	begin
		rsp_next.tag      = wr_pick ? i_wr_req.tag : i_rd_req.tag;
		rsp_next.is_write = wr_pick;
		rsp_next.err      = err;
		// only a good read carries data back
		rsp_next.rdata    = (!wr_pick && !err) ? i_bank_rdata : '0;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_rsp_valid <= 1'b0;
		else if (rsp_free)
			o_rsp_valid <= wr_grant || rd_grant;
	end

	// grants only happen with a free slot so a held response never moves
	always_ff @(posedge i_clk)
	begin
		if (wr_grant || rd_grant)
			o_rsp <= rsp_next;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	a_one_grant : assert property (
		@(posedge i_clk) disable iff (i_reset)
		!(wr_grant && rd_grant)
	) else $error("both channels granted in one cycle");

	// response must wait for the consumer
	a_rsp_hold : assert property (
		@(posedge i_clk) disable iff (i_reset)
		(o_rsp_valid && i_rsp_stall) |=> (o_rsp_valid && $stable(o_rsp))
	) else $error("response changed while stalled");

endmodule

// File: hw/periph_regs.sv
`timescale 1ns/1ps

module periph_regs (
	input  logic                              i_clk,
	input  logic [fabric_pkg::NUM_SLAVES-1:0] i_sel,
	input  logic                              i_we,
	input  logic [fabric_pkg::WORD_IDX_W-1:0] i_idx,
	input  logic [fabric_pkg::DATA_W-1:0]     i_wdata,
	input  logic [fabric_pkg::STRB_W-1:0]     i_strb,
	output logic [fabric_pkg::DATA_W-1:0]     o_rdata
);
	import fabric_pkg::*;

	// read word of each slave at the current index
	logic [DATA_W-1:0] slave_rdata [NUM_SLAVES];

	////////////////////////////////////////////////////////////////////////////
	// slaves
	////////////////////////////////////////////////////////////////////////////

	genvar s;
	generate
		for (s = 0; s < NUM_SLAVES; s++)
		begin : g_slave
			if (s == ROM_SLAVE)
			begin : g_rom
				// id pattern with the word index in the low nibble
				// writes never reach this slave
				assign slave_rdata[s] = {ROM_ID[DATA_W-1:WORD_IDX_W], i_idx};
			end
			else
			begin : g_ram
				// contents undefined until first written
				logic [DATA_W-1:0] mem [RAM_WORDS];

				// byte lanes written only where the strobe is set
				always_ff @(posedge i_clk)
				begin
					if (i_we && i_sel[s])
					begin
						for (int b = 0; b < STRB_W; b++)
						begin
							if (i_strb[b])
								mem[i_idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
						end
					end
				end

				// asynchronous read
				assign slave_rdata[s] = mem[i_idx];
			end
		end
	endgenerate

	////////////////////////////////////////////////////////////////////////////
	// read mux
	////////////////////////////////////////////////////////////////////////////

	// select is one-hot, so an or of the selected words is enough
	always_comb
	begin
		o_rdata = '0;
		for (int k = 0; k < NUM_SLAVES; k++)
		begin
			if (i_sel[k])
				o_rdata = o_rdata | slave_rdata[k];
		end
	end

endmodule

// File: hw/bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric (
	input  logic                i_clk,
	input  logic                i_reset,
	// write channel
	input  logic                i_wr_valid,
	output logic                o_wr_stall,
	input  fabric_pkg::wr_req_t i_wr_req,
	// read channel
	input  logic                i_rd_valid,
	output logic                o_rd_stall,
	input  fabric_pkg::rd_req_t i_rd_req,
	// responses
	output logic                o_rsp_valid,
	input  logic                i_rsp_stall,
	output fabric_pkg::rsp_t    o_rsp
);
	import fabric_pkg::*;

	// write decoder to arbiter
	logic    wr_dec_valid;
	logic    wr_dec_stall;
	decode_t wr_dec_decode;
	wr_req_t wr_dec_req;

	// read decoder to arbiter
	logic    rd_dec_valid;
	logic    rd_dec_stall;
	decode_t rd_dec_decode;
	rd_req_t rd_dec_req;

	// arbiter to slave bank
	logic [NUM_SLAVES-1:0] bank_sel;
	logic                  bank_we;
	logic [WORD_IDX_W-1:0] bank_idx;
	logic [DATA_W-1:0]     bank_wdata;
	logic [STRB_W-1:0]     bank_strb;
	logic [DATA_W-1:0]     bank_rdata;

	////////////////////////////////////////////////////////////////////////////
	// decoders
	////////////////////////////////////////////////////////////////////////////

	// write side refuses the rom
	addr_decode #(
		.PAYLOAD_T      (wr_req_t),
		.ACCESS_ALLOWED (WR_ALLOWED)
	) u_wr_decode (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_valid   (i_wr_valid),
		.o_stall   (o_wr_stall),
		.i_addr    (i_wr_req.addr),
		.i_payload (i_wr_req),
		.o_valid   (wr_dec_valid),
		.i_stall   (wr_dec_stall),
		.o_decode  (wr_dec_decode),
		.o_payload (wr_dec_req)
	);

	addr_decode #(
		.PAYLOAD_T      (rd_req_t),
		.ACCESS_ALLOWED (RD_ALLOWED)
	) u_rd_decode (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_valid   (i_rd_valid),
		.o_stall   (o_rd_stall),
		.i_addr    (i_rd_req.addr),
		.i_payload (i_rd_req),
		.o_valid   (rd_dec_valid),
		.i_stall   (rd_dec_stall),
		.o_decode  (rd_dec_decode),
		.o_payload (rd_dec_req)
	);

	////////////////////////////////////////////////////////////////////////////
	// arbiter and slave bank
	////////////////////////////////////////////////////////////////////////////

	access_arbiter u_arbiter (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_wr_valid   (wr_dec_valid),
		.o_wr_stall   (wr_dec_stall),
		.i_wr_decode  (wr_dec_decode),
		.i_wr_req     (wr_dec_req),
		.i_rd_valid   (rd_dec_valid),
		.o_rd_stall   (rd_dec_stall),
		.i_rd_decode  (rd_dec_decode),
		.i_rd_req     (rd_dec_req),
		.o_bank_sel   (bank_sel),
		.o_bank_we    (bank_we),
		.o_bank_idx   (bank_idx),
		.o_bank_wdata (bank_wdata),
		.o_bank_strb  (bank_strb),
		.i_bank_rdata (bank_rdata),
		.o_rsp_valid  (o_rsp_valid),
		.i_rsp_stall  (i_rsp_stall),
		.o_rsp        (o_rsp)
	);

	periph_regs u_periph_regs (
		.i_clk   (i_clk),
		.i_sel   (bank_sel),
		.i_we    (bank_we),
		.i_idx   (bank_idx),
		.i_wdata (bank_wdata),
		.i_strb  (bank_strb),
		.o_rdata (bank_rdata)
	);

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic o_clk,
	output logic o_reset
);
	// half of the 20 ns period
	localparam int HALF_PERIOD = 10;
	// reset spans this many rising edges
	localparam int RESET_CYCLES = 2;

	// free running clock, starts low
	initial
	begin
		o_clk = 1'b0;
		forever
			#(HALF_PERIOD) o_clk = ~o_clk;
	end

	// synchronous reset, released on a rising edge
	initial
	begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

// File: test/tb_bus_fabric.sv
`timescale 1ns/1ps

module tb_bus_fabric;
	import fabric_pkg::*;

	// random transactions after the startup fill and readback
	localparam int NUM_TRANS = 400;
	// percent of cycles with response back-pressure
	localparam int STALL_PCT = 30;
	// percent chance that a ready request waits a cycle
	localparam int IDLE_PCT = 20;
	localparam int MAX_CYCLES = NUM_TRANS * 10 + 200;
	localparam int NUM_TAGS = 1 << TAG_W;

	logic    clk;
	logic    reset;
	// stimulus side of the dut
	logic    wr_valid;
	wr_req_t wr_req;
	logic    rd_valid;
	rd_req_t rd_req;
	logic    rsp_stall;
	// dut outputs
	logic    wr_stall;
	logic    rd_stall;
	logic    rsp_valid;
	rsp_t    rsp;

	// requests waiting to be issued with the tag filled in at issue
	wr_req_t wr_queue[$];
	rd_req_t rd_queue[$];

	// outstanding requests by tag
	logic              tag_busy   [NUM_TAGS];
	logic              tag_write  [NUM_TAGS];
	logic [ADDR_W-1:0] tag_addr   [NUM_TAGS];
	logic [DATA_W-1:0] tag_data   [NUM_TAGS];
	logic [STRB_W-1:0] tag_strb   [NUM_TAGS];
	int                tag_accept [NUM_TAGS];

	// reference ram contents where slot 2 stands for slave 3
	logic [DATA_W-1:0] model_mem [3][RAM_WORDS];

	integer           seed;
	int               cycle;
	int               outstanding;
	logic [TAG_W-1:0] next_tag;
	// shadows of the valid lines that update at once
	logic             wr_active;
	logic             rd_active;
	logic             random_mode;
	logic             strict_latency;

	tb_clock u_clock (
		.o_clk   (clk),
		.o_reset (reset)
	);

	bus_fabric uut (
		.i_clk       (clk),
		.i_reset     (reset),
		.i_wr_valid  (wr_valid),
		.o_wr_stall  (wr_stall),
		.i_wr_req    (wr_req),
		.i_rd_valid  (rd_valid),
		.o_rd_stall  (rd_stall),
		.i_rd_req    (rd_req),
		.o_rsp_valid (rsp_valid),
		.i_rsp_stall (rsp_stall),
		.o_rsp       (rsp)
	);

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic int unsigned rand_below(input int unsigned n);
		rand_below = $unsigned($random(seed)) % n;
	endfunction

	// slave number from the address map with 4 standing for the hole
	function automatic int slave_of(input logic [ADDR_W-1:0] addr);
		if (addr[15])
			slave_of = 3;
		else if (addr[15:12] <= 4'h2)
			slave_of = int'(addr[15:12]);
		else
			slave_of = 4;
	endfunction

	// random address in one slave window where 4 picks the hole 0x3000..0x7fff
	function automatic logic [ADDR_W-1:0] addr_in(input int s);
		logic [31:0] r;
		logic [31:0] hole;
		r = $random(seed);
		hole = 32'h3000 + (r % 32'h5000);
		case (s)
			0:       addr_in = {4'h0, r[11:0]};
			1:       addr_in = {4'h1, r[11:0]};
			2:       addr_in = {4'h2, r[11:0]};
			3:       addr_in = {1'b1, r[14:0]};
			default: addr_in = hole[ADDR_W-1:0];
		endcase
	endfunction

	task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("mismatch at %0t ns: %s, got %0h expected %0h",
				$time, what, actual, expected);
			$display("TESTS FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	// a request gets the next tag and goes into the table
	task automatic claim_tag(input logic is_write, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
		tag_busy[next_tag]  = 1'b1;
		tag_write[next_tag] = is_write;
		tag_addr[next_tag]  = addr;
		tag_data[next_tag]  = data;
		tag_strb[next_tag]  = strb;
		outstanding++;
		next_tag++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// response model
	////////////////////////////////////////////////////////////////////////////

	// responses leave in execution order, so the model runs the access here
	task automatic check_response(input rsp_t r);
		logic [TAG_W-1:0]      t;
		int                    s;
		logic [WORD_IDX_W-1:0] idx;
		logic                  exp_err;
		logic [DATA_W-1:0]     exp_data;
		t = r.tag;
		exp_data = '0;
		check_equal(tag_busy[t], 1'b1, "response for a tag that is not outstanding");
		check_equal(r.is_write, tag_write[t], "is_write differs from the request");
		if (strict_latency)
			check_equal(cycle - tag_accept[t], 2, "cycles from acceptance to response");
		s = slave_of(tag_addr[t]);
		idx = tag_addr[t][5:2];
		if (tag_write[t])
		begin
			// rom and hole refuse writes
			exp_err = (s == 4) || (s == 2);
			if (!exp_err)
			begin
				for (int b = 0; b < STRB_W; b++)
				begin
					if (tag_strb[t][b])
						model_mem[(s == 3) ? 2 : s][idx][b*8 +: 8] = tag_data[t][b*8 +: 8];
				end
			end
		end
		else
		begin
			exp_err = (s == 4);
			// id word with its low nibble cleared and the index put in
			if (s == 2)
				exp_data = (ROM_ID & 32'hFFFF_FFF0) | DATA_W'(idx);
			else if (s != 4)
				exp_data = model_mem[(s == 3) ? 2 : s][idx];
		end
		check_equal(r.err, exp_err, "err flag");
		// writes carry no data except that an error must show zero
		if (!tag_write[t] || exp_err)
			check_equal(r.rdata, exp_data, "response data");
		tag_busy[t] = 1'b0;
		outstanding--;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// per-cycle driver
	////////////////////////////////////////////////////////////////////////////

	task automatic cycle_step();
		wr_req_t w;
		rd_req_t r;
		@(posedge clk);
		cycle++;
		if (cycle > MAX_CYCLES)
		begin
			$display("timeout: traffic did not drain within %0d cycles", MAX_CYCLES);
			$display("TESTS FAILED");
			$fatal(1, "timeout");
		end
		// response taken on this edge
		if (rsp_valid && !rsp_stall)
			check_response(rsp);
		// requests taken on this edge
		if (wr_active && !wr_stall)
		begin
			tag_accept[wr_req.tag] = cycle;
			wr_active = 1'b0;
		end
		if (rd_active && !rd_stall)
		begin
			tag_accept[rd_req.tag] = cycle;
			rd_active = 1'b0;
		end
		// a free channel picks up the next request if a tag is free
		if (!wr_active && wr_queue.size() != 0 && !tag_busy[next_tag]
			&& (!random_mode || rand_below(100) >= IDLE_PCT))
		begin
			w = wr_queue.pop_front();
			w.tag = next_tag;
			claim_tag(1'b1, w.addr, w.data, w.strb);
			wr_req <= w;
			wr_active = 1'b1;
		end
		if (!rd_active && rd_queue.size() != 0 && !tag_busy[next_tag]
			&& (!random_mode || rand_below(100) >= IDLE_PCT))
		begin
			r = rd_queue.pop_front();
			r.tag = next_tag;
			claim_tag(1'b0, r.addr, '0, '0);
			rd_req <= r;
			rd_active = 1'b1;
		end
		wr_valid  <= wr_active;
		rd_valid  <= rd_active;
		rsp_stall <= random_mode && (rand_below(100) < STALL_PCT);
	endtask

	task automatic run_queues();
		while (wr_queue.size() != 0 || rd_queue.size() != 0 || wr_active || rd_active
			|| outstanding != 0)
		begin
			cycle_step();
		end
	endtask

	// one random request on a random channel
	task automatic queue_random();
		wr_req_t w;
		rd_req_t r;
		int      s;
		int      kind;
		kind = rand_below(100);
		if (rand_below(2) == 0)
		begin
			// mostly ram slaves and otherwise the rom or the hole
			if (kind < 70)
				s = (rand_below(3) == 2) ? 3 : kind % 2;
			else
				s = (rand_below(2) == 0) ? 2 : 4;
			w.tag  = '0;
			w.addr = addr_in(s);
			w.data = $random(seed);
			w.strb = STRB_W'(rand_below(16));
			wr_queue.push_back(w);
		end
		else
		begin
			s = (kind < 70) ? rand_below(4) : 4;
			r.tag  = '0;
			r.addr = addr_in(s);
			rd_queue.push_back(r);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		wr_req_t w;
		rd_req_t r;
		wr_valid  = 1'b0;
		wr_req    = '0;
		rd_valid  = 1'b0;
		rd_req    = '0;
		rsp_stall = 1'b0;
		seed = 32'h6d43;
		cycle = 0;
		outstanding = 0;
		next_tag = '0;
		wr_active = 1'b0;
		rd_active = 1'b0;
		random_mode = 1'b0;
		strict_latency = 1'b1;
		for (int t = 0; t < NUM_TAGS; t++)
			tag_busy[t] = 1'b0;

		// no response during reset nor on the cycle after release
		do
		begin
			@(negedge clk);
			check_equal(rsp_valid, 1'b0, "response valid during reset");
		end
		while (reset);
		@(negedge clk);
		check_equal(rsp_valid, 1'b0, "response valid right after reset");

		// fill all ram words through the write channel alone
		for (int s = 0; s < NUM_SLAVES; s++)
		begin
			for (int i = 0; i < RAM_WORDS; i++)
			begin
				if (s != 2)
				begin
					w.tag  = '0;
					w.addr = addr_in(s) & 16'hFFC3 | ADDR_W'(i << 2);
					w.data = $random(seed);
					w.strb = '1;
					wr_queue.push_back(w);
				end
			end
		end
		run_queues();

		// read every word back, rom included, through the read channel alone
		for (int s = 0; s < NUM_SLAVES; s++)
		begin
			for (int i = 0; i < RAM_WORDS; i++)
			begin
				r.tag  = '0;
				r.addr = addr_in(s) & 16'hFFC3 | ADDR_W'(i << 2);
				rd_queue.push_back(r);
			end
		end
		run_queues();

		// both channels with back-pressure and no fixed latency
		strict_latency = 1'b0;
		random_mode = 1'b1;
		for (int n = 0; n < NUM_TRANS; n++)
			queue_random();
		run_queues();

		// any late response would hit a tag that is no longer outstanding
		repeat (4)
			cycle_step();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: src.f
hw/fabric_pkg.sv
hw/addr_decode.sv
hw/access_arbiter.sv
hw/periph_regs.sv
hw/bus_fabric.sv
test/tb_clock.sv
test/tb_bus_fabric.sv
